//--- design/lsu_pkg.sv
package lsu_pkg;

    localparam int xlen = 32;
    localparam int imm_w = 12; // sign-extended in agen

    // memory opcodes, bit 3 marks a store
    localparam int op_w = 4;
    localparam logic [op_w-1:0] op_lb  = 4'b0000;
    localparam logic [op_w-1:0] op_lh  = 4'b0001;
    localparam logic [op_w-1:0] op_lw  = 4'b0010;
    localparam logic [op_w-1:0] op_lbu = 4'b0100;
    localparam logic [op_w-1:0] op_lhu = 4'b0101;
    localparam logic [op_w-1:0] op_sb  = 4'b1000;
    localparam logic [op_w-1:0] op_sh  = 4'b1001;
    localparam logic [op_w-1:0] op_sw  = 4'b1010;

    localparam int size_w = 2;
    localparam logic [size_w-1:0] size_byte = 2'd0;
    localparam logic [size_w-1:0] size_half = 2'd1;
    localparam logic [size_w-1:0] size_word = 2'd2;

endpackage

//--- design/ls_decode.sv
`timescale 1ns/1ns

module ls_decode #(
    parameter int num_entries = 16,
    localparam int tag_w = $clog2(num_entries)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       disp_valid,
    input  logic [lsu_pkg::op_w-1:0]   disp_op,
    input  logic [lsu_pkg::imm_w-1:0]  disp_imm,
    input  logic [tag_w-1:0]           disp_rd_tag,
    input  logic [tag_w-1:0]           disp_rs1_tag,
    input  logic [lsu_pkg::xlen-1:0]   disp_rs1_data,
    input  logic [tag_w-1:0]           disp_rs2_tag,
    input  logic [lsu_pkg::xlen-1:0]   disp_rs2_data,
    output logic                       disp_ready,
    input  logic                       entry_busy,
    output logic                       dec_valid,
    output logic                       dec_is_store,
    output logic [lsu_pkg::size_w-1:0] dec_size,
    output logic                       dec_unsigned,
    output logic [lsu_pkg::imm_w-1:0]  dec_imm,
    output logic [tag_w-1:0]           dec_rd_tag,
    output logic [tag_w-1:0]           dec_rs1_tag,
    output logic [lsu_pkg::xlen-1:0]   dec_rs1_data,
    output logic [tag_w-1:0]           dec_rs2_tag,
    output logic [lsu_pkg::xlen-1:0]   dec_rs2_data
);
    import lsu_pkg::*;

    logic              live; // set once out of reset
    logic              is_mem;
    logic              is_store;
    logic              is_unsigned;
    logic [size_w-1:0] size;

    always_comb begin
        is_mem = 1'b1;
        is_store = 1'b0;
        is_unsigned = 1'b0;
        size = size_word;
        case (disp_op)
            op_lb:  size = size_byte;
            op_lh:  size = size_half;
            op_lw:  size = size_word;
            op_lbu: begin
                size = size_byte;
                is_unsigned = 1'b1;
            end
            op_lhu: begin
                size = size_half;
                is_unsigned = 1'b1;
            end
            op_sb: begin
                size = size_byte;
                is_store = 1'b1;
            end
            op_sh: begin
                size = size_half;
                is_store = 1'b1;
            end
            op_sw:  is_store = 1'b1;
            default: is_mem = 1'b0; // accepted, then dropped
        endcase
    end

    // stall while the target entry is still taken
    assign disp_ready = live && !(dec_valid && entry_busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            live <= 1'b1;
            if (disp_ready)
                dec_valid <= disp_valid && is_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid && disp_ready) begin
            dec_is_store <= is_store;
            dec_size <= size;
            dec_unsigned <= is_unsigned;
            dec_imm <= disp_imm;
            dec_rd_tag <= disp_rd_tag;
            dec_rs1_tag <= disp_rs1_tag;
            dec_rs1_data <= disp_rs1_data;
            dec_rs2_tag <= disp_rs2_tag;
            dec_rs2_data <= disp_rs2_data;
        end
    end

endmodule

//--- design/ls_buffer.sv
`timescale 1ns/1ns

module ls_buffer #(
    parameter int num_entries = 16,
    localparam int tag_w = $clog2(num_entries)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dec_valid,
    input  logic                       dec_is_store,
    input  logic [lsu_pkg::size_w-1:0] dec_size,
    input  logic                       dec_unsigned,
    input  logic [lsu_pkg::imm_w-1:0]  dec_imm,
    input  logic [tag_w-1:0]           dec_rd_tag,
    input  logic [tag_w-1:0]           dec_rs1_tag,
    input  logic [lsu_pkg::xlen-1:0]   dec_rs1_data,
    input  logic [tag_w-1:0]           dec_rs2_tag,
    input  logic [lsu_pkg::xlen-1:0]   dec_rs2_data,
    output logic                       entry_busy,
    input  logic                       ex_valid,
    input  logic [tag_w-1:0]           ex_tag,
    input  logic [lsu_pkg::xlen-1:0]   ex_data,
    input  logic                       commit_valid,
    input  logic [tag_w-1:0]           commit_tag,
    input  logic                       ld_valid,
    input  logic [tag_w-1:0]           ld_tag,
    input  logic [lsu_pkg::xlen-1:0]   ld_data,
    output logic                       iss_valid,
    output logic                       iss_is_store,
    output logic [lsu_pkg::size_w-1:0] iss_size,
    output logic                       iss_unsigned,
    output logic [tag_w-1:0]           iss_tag,
    output logic [lsu_pkg::xlen-1:0]   iss_base,
    output logic [lsu_pkg::imm_w-1:0]  iss_imm,
    output logic [lsu_pkg::xlen-1:0]   iss_store_data,
    output logic                       res_valid,
    output logic [tag_w-1:0]           res_tag,
    output logic [lsu_pkg::xlen-1:0]   res_data
);
    import lsu_pkg::*;

    logic [num_entries-1:0] occupied;
    logic [num_entries-1:0] in_flight;
    logic [num_entries-1:0] committed;
    logic [num_entries-1:0] is_store;
    logic [num_entries-1:0] uns;
    logic [num_entries-1:0] r1;
    logic [num_entries-1:0] r2;
    logic [size_w-1:0]      size [num_entries];
    logic [imm_w-1:0]       imm  [num_entries];
    logic [tag_w-1:0]       t1   [num_entries];
    logic [tag_w-1:0]       t2   [num_entries];
    logic [xlen-1:0]        d1   [num_entries]; // base
    logic [xlen-1:0]        d2   [num_entries]; // store data

    logic             wr_en;
    logic             st_go;
    logic             ld_go;
    logic [tag_w-1:0] st_idx;
    logic [tag_w-1:0] ld_idx;
    logic [tag_w-1:0] sel;

    // {ready, value} of an operand after snooping both broadcasts
    function automatic logic [xlen:0] snoop(input logic [tag_w-1:0] tag, input logic rdy,
                                            input logic [xlen-1:0] data);
        if (rdy || tag == '0)
            return {1'b1, data};
        if (ex_valid && ex_tag == tag)
            return {1'b1, ex_data};
        if (res_valid && res_tag == tag)
            return {1'b1, res_data};
        return {1'b0, data};
    endfunction

    assign entry_busy = occupied[dec_rd_tag];
    assign wr_en = dec_valid && !entry_busy;

    // committed stores go ahead of the lowest ready load
    always_comb begin
        st_go = 1'b0;
        ld_go = 1'b0;
        st_idx = '0;
        ld_idx = '0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (occupied[i] && is_store[i] && committed[i] && r1[i] && r2[i]) begin
                st_go = 1'b1;
                st_idx = tag_w'(i);
            end
            if (occupied[i] && !is_store[i] && !in_flight[i] && r1[i]) begin
                ld_go = 1'b1;
                ld_idx = tag_w'(i);
            end
        end
    end

    assign sel = st_go ? st_idx : ld_idx;

    // selected entry feeds agen directly
    assign iss_valid = st_go || ld_go;
    assign iss_is_store = is_store[sel];
    assign iss_size = size[sel];
    assign iss_unsigned = uns[sel];
    assign iss_tag = sel;
    assign iss_base = d1[sel];
    assign iss_imm = imm[sel];
    assign iss_store_data = d2[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            occupied <= '0;
            in_flight <= '0;
            committed <= '0;
            res_valid <= 1'b0;
        end else begin
            if (ld_valid) begin // returning load frees its entry
                occupied[ld_tag] <= 1'b0;
                in_flight[ld_tag] <= 1'b0;
            end
            if (commit_valid)
                committed[commit_tag] <= 1'b1;
            if (st_go) begin // stores leave at issue
                occupied[st_idx] <= 1'b0;
                committed[st_idx] <= 1'b0;
            end else if (ld_go) begin
                in_flight[ld_idx] <= 1'b1;
            end
            if (wr_en)
                occupied[dec_rd_tag] <= 1'b1;
            res_valid <= ld_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_entries; i++) begin
            {r1[i], d1[i]} <= snoop(t1[i], r1[i], d1[i]);
            {r2[i], d2[i]} <= snoop(t2[i], r2[i], d2[i]);
        end
        if (wr_en) begin
            is_store[dec_rd_tag] <= dec_is_store;
            uns[dec_rd_tag] <= dec_unsigned;
            size[dec_rd_tag] <= dec_size;
            imm[dec_rd_tag] <= dec_imm;
            t1[dec_rd_tag] <= dec_rs1_tag;
            t2[dec_rd_tag] <= dec_rs2_tag;
            {r1[dec_rd_tag], d1[dec_rd_tag]} <= snoop(dec_rs1_tag, 1'b0, dec_rs1_data);
            {r2[dec_rd_tag], d2[dec_rd_tag]} <= snoop(dec_rs2_tag, 1'b0, dec_rs2_data);
        end
        res_tag <= ld_tag;
        res_data <= ld_data;
    end

    // ROB may only commit a store that sits in the buffer
    a_commit_store: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> occupied[commit_tag] && is_store[commit_tag])
        else $error("commit to tag %0d which holds no store", commit_tag);

    a_write_free: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> !in_flight[dec_rd_tag] && !committed[dec_rd_tag])
        else $error("dispatch overwrites live entry %0d", dec_rd_tag);

    // no load gets marked in flight while a store leaves
    a_one_issue: assert property (@(posedge clk) disable iff (!rst_n)
        st_go |=> (in_flight & ~$past(in_flight)) == '0)
        else $error("store and load issued together");

endmodule

//--- design/agen_stage.sv
`timescale 1ns/1ns

module agen_stage #(
    parameter int num_entries = 16,
    localparam int tag_w = $clog2(num_entries)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       iss_valid,
    input  logic                       iss_is_store,
    input  logic [lsu_pkg::size_w-1:0] iss_size,
    input  logic                       iss_unsigned,
    input  logic [tag_w-1:0]           iss_tag,
    input  logic [lsu_pkg::xlen-1:0]   iss_base,
    input  logic [lsu_pkg::imm_w-1:0]  iss_imm,
    input  logic [lsu_pkg::xlen-1:0]   iss_store_data,
    output logic                       acc_valid,
    output logic                       acc_is_store,
    output logic [lsu_pkg::size_w-1:0] acc_size,
    output logic                       acc_unsigned,
    output logic [tag_w-1:0]           acc_tag,
    output logic [lsu_pkg::xlen-1:0]   acc_addr,
    output logic [lsu_pkg::xlen-1:0]   acc_wdata
);
    import lsu_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            acc_valid <= 1'b0;
        else
            acc_valid <= iss_valid;
    end

    always_ff @(posedge clk) begin
        acc_is_store <= iss_is_store;
        acc_size <= iss_size;
        acc_unsigned <= iss_unsigned;
        acc_tag <= iss_tag;
        acc_addr <= iss_base + xlen'($signed(iss_imm)); // imm sign-extended
        acc_wdata <= iss_store_data;
    end

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid |-> (acc_size != size_half || !acc_addr[0]) &&
                      (acc_size != size_word || acc_addr[1:0] == 2'b00))
        else $error("misaligned access at %h", acc_addr);

endmodule

//--- design/data_mem.sv
`timescale 1ns/1ns

module data_mem #(
    parameter int num_entries = 16,
    parameter int mem_words = 256,
    localparam int tag_w = $clog2(num_entries)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       acc_valid,
    input  logic                       acc_is_store,
    input  logic [lsu_pkg::size_w-1:0] acc_size,
    input  logic                       acc_unsigned,
    input  logic [tag_w-1:0]           acc_tag,
    input  logic [lsu_pkg::xlen-1:0]   acc_addr,
    input  logic [lsu_pkg::xlen-1:0]   acc_wdata,
    output logic                       ld_valid,
    output logic [tag_w-1:0]           ld_tag,
    output logic [lsu_pkg::xlen-1:0]   ld_data
);
    import lsu_pkg::*;

    localparam int aw = $clog2(mem_words);

    logic [xlen-1:0] mem [mem_words];
    logic [aw-1:0]   widx;
    logic [4:0]      lane_sh;  // bit offset of the low lane
    logic [3:0]      be;
    logic [xlen-1:0] wlanes;
    logic [xlen-1:0] rlanes;
    logic [xlen-1:0] ld_next;

    assign widx = acc_addr[aw+1:2];
    assign lane_sh = {acc_addr[1:0], 3'b000};
    assign wlanes = acc_wdata << lane_sh;
    assign rlanes = mem[widx] >> lane_sh;

    always_comb begin
        case (acc_size)
            size_byte: be = 4'b0001 << acc_addr[1:0];
            size_half: be = 4'b0011 << acc_addr[1:0];
            default:   be = 4'b1111;
        endcase
    end

    always_comb begin
        case (acc_size)
            size_byte: ld_next = acc_unsigned ? {24'd0, rlanes[7:0]}
                                              : {{24{rlanes[7]}}, rlanes[7:0]};
            size_half: ld_next = acc_unsigned ? {16'd0, rlanes[15:0]}
                                              : {{16{rlanes[15]}}, rlanes[15:0]};
            default:   ld_next = rlanes;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ld_valid <= 1'b0;
        else
            ld_valid <= acc_valid && !acc_is_store;
    end

    always_ff @(posedge clk) begin
        if (acc_valid && acc_is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b])
                    mem[widx][8*b +: 8] <= wlanes[8*b +: 8];
            end
        end
        ld_tag <= acc_tag;
        ld_data <= ld_next;
    end

    a_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        acc_valid |-> (acc_addr >> 2) < mem_words)
        else $error("address %h beyond data memory", acc_addr);

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ns

module lsu_top #(
    parameter int num_entries = 16,
    parameter int mem_words = 256,
    localparam int tag_w = $clog2(num_entries)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      disp_valid,
    input  logic [lsu_pkg::op_w-1:0]  disp_op,
    input  logic [lsu_pkg::imm_w-1:0] disp_imm,
    input  logic [tag_w-1:0]          disp_rd_tag,
    input  logic [tag_w-1:0]          disp_rs1_tag,
    input  logic [lsu_pkg::xlen-1:0]  disp_rs1_data,
    input  logic [tag_w-1:0]          disp_rs2_tag,
    input  logic [lsu_pkg::xlen-1:0]  disp_rs2_data,
    output logic                      disp_ready,
    input  logic                      ex_valid,
    input  logic [tag_w-1:0]          ex_tag,
    input  logic [lsu_pkg::xlen-1:0]  ex_data,
    input  logic                      commit_valid,
    input  logic [tag_w-1:0]          commit_tag,
    output logic                      res_valid,
    output logic [tag_w-1:0]          res_tag,
    output logic [lsu_pkg::xlen-1:0]  res_data
);
    import lsu_pkg::*;

    // decode to buffer
    logic              dec_valid;
    logic              dec_is_store;
    logic [size_w-1:0] dec_size;
    logic              dec_unsigned;
    logic [imm_w-1:0]  dec_imm;
    logic [tag_w-1:0]  dec_rd_tag;
    logic [tag_w-1:0]  dec_rs1_tag;
    logic [xlen-1:0]   dec_rs1_data;
    logic [tag_w-1:0]  dec_rs2_tag;
    logic [xlen-1:0]   dec_rs2_data;
    logic              entry_busy;

    // buffer to agen
    logic              iss_valid;
    logic              iss_is_store;
    logic [size_w-1:0] iss_size;
    logic              iss_unsigned;
    logic [tag_w-1:0]  iss_tag;
    logic [xlen-1:0]   iss_base;
    logic [imm_w-1:0]  iss_imm;
    logic [xlen-1:0]   iss_store_data;

    // agen to memory
    logic              acc_valid;
    logic              acc_is_store;
    logic [size_w-1:0] acc_size;
    logic              acc_unsigned;
    logic [tag_w-1:0]  acc_tag;
    logic [xlen-1:0]   acc_addr;
    logic [xlen-1:0]   acc_wdata;

    // load return
    logic              ld_valid;
    logic [tag_w-1:0]  ld_tag;
    logic [xlen-1:0]   ld_data;

    ls_decode #(.num_entries(num_entries)) u_decode (.*);

    ls_buffer #(.num_entries(num_entries)) u_buffer (.*);

    agen_stage #(.num_entries(num_entries)) u_agen (.*);

    data_mem #(
        .num_entries(num_entries),
        .mem_words  (mem_words)
    ) u_mem (.*);

endmodule

//--- sim/tb_lsu.sv
`timescale 1ns/1ns

module tb_lsu;
    import lsu_pkg::*;

    localparam int num_entries = 16;
    localparam int tag_w = $clog2(num_entries);

    logic              clk;
    logic              rst_n;
    logic              disp_valid;
    logic [op_w-1:0]   disp_op;
    logic [imm_w-1:0]  disp_imm;
    logic [tag_w-1:0]  disp_rd_tag;
    logic [tag_w-1:0]  disp_rs1_tag;
    logic [xlen-1:0]   disp_rs1_data;
    logic [tag_w-1:0]  disp_rs2_tag;
    logic [xlen-1:0]   disp_rs2_data;
    logic              disp_ready;
    logic              ex_valid;
    logic [tag_w-1:0]  ex_tag;
    logic [xlen-1:0]   ex_data;
    logic              commit_valid;
    logic [tag_w-1:0]  commit_tag;
    logic              res_valid;
    logic [tag_w-1:0]  res_tag;
    logic [xlen-1:0]   res_data;

    // expected loads in dispatch order
    logic [tag_w-1:0]  exp_tag [$];
    logic [xlen-1:0]   exp_data [$];
    bit                used [256];

    logic [31:0] rng_state;
    int          errors;
    int          res_errors;
    int          res_checks;
    int          matched;
    int          cycles;
    int          cycle_limit;
    int          stall_cycles;

    lsu_top #(
        .num_entries(num_entries),
        .mem_words  (256)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic dispatch(input logic [op_w-1:0] op, input logic [imm_w-1:0] imm,
                            input logic [tag_w-1:0] rd, input logic [tag_w-1:0] t1,
                            input logic [xlen-1:0] d1, input logic [tag_w-1:0] t2,
                            input logic [xlen-1:0] d2);
        disp_valid = 1'b1;
        disp_op = op;
        disp_imm = imm;
        disp_rd_tag = rd;
        disp_rs1_tag = t1;
        disp_rs1_data = d1;
        disp_rs2_tag = t2;
        disp_rs2_data = d2;
        while (!disp_ready)
            next_cycle(); // payload held while stalled
        next_cycle();
        disp_valid = 1'b0;
    endtask

    task automatic broadcast(input logic [tag_w-1:0] tag, input logic [xlen-1:0] data);
        ex_valid = 1'b1;
        ex_tag = tag;
        ex_data = data;
        next_cycle();
        ex_valid = 1'b0;
    endtask

    task automatic commit(input logic [tag_w-1:0] tag);
        commit_valid = 1'b1;
        commit_tag = tag;
        next_cycle();
        commit_valid = 1'b0;
    endtask

    // result monitor, timeout and stall count
    always @(posedge clk) begin
        int idx;
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d loads still pending",
                     cycles, exp_tag.size() - matched);
            $display("Test failed");
            $finish;
        end else begin
            if (rst_n && cycles > 8 && !disp_ready)
                stall_cycles++;
            if (rst_n && res_valid) begin
                idx = -1;
                foreach (exp_tag[i]) begin
                    if (idx < 0 && !used[i] && exp_tag[i] == res_tag)
                        idx = i;
                end
                if (idx < 0) begin
                    $display("result for tag %0d arrived with no load pending on it", res_tag);
                    res_errors++;
                end else begin
                    used[idx] = 1'b1;
                    matched++;
                    res_checks++;
                    if (res_data !== exp_data[idx]) begin
                        $display("Fail res_data tag %h: got %h expected %h",
                                 res_tag, res_data, exp_data[idx]);
                        res_errors++;
                    end
                end
            end
        end
    end

    initial begin
        int          fd;
        int          lines;
        int          cnt;
        string       line;
        string       rest;
        byte         cmd;
        logic [31:0] op;
        logic [31:0] imm;
        logic [31:0] rd;
        logic [31:0] t1;
        logic [31:0] d1;
        logic [31:0] t2;
        logic [31:0] d2;
        logic [31:0] expv;

        rst_n = 1'b0;
        disp_valid = 1'b0;
        disp_op = '0;
        disp_imm = '0;
        disp_rd_tag = '0;
        disp_rs1_tag = '0;
        disp_rs1_data = '0;
        disp_rs2_tag = '0;
        disp_rs2_data = '0;
        ex_valid = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        commit_valid = 1'b0;
        commit_tag = '0;
        rng_state = 32'h80c0_c8ba;
        errors = 0;
        lines = 0;

        fd = $fopen("sim/lsu_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/lsu_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0)
                lines++;
            $fclose(fd);
        end
        cycle_limit = 40 * lines + 200;

        repeat (5) @(posedge clk);
        #2;
        if (disp_ready !== 1'b0) begin
            $display("Fail disp_ready in reset: got %h expected 0", disp_ready);
            errors++;
        end
        if (res_valid !== 1'b0) begin
            $display("Fail res_valid in reset: got %h expected 0", res_valid);
            errors++;
        end
        rst_n = 1'b1;
        next_cycle();

        if (lines > 0) begin
            fd = $fopen("sim/lsu_tests.txt", "r");
            while ($fgets(line, fd) > 0) begin
                cmd = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                case (cmd)
                    "#", " ", "\n", "\r": ;
                    "D": begin
                        cnt = $sscanf(rest, "%h %h %h %h %h %h %h %h",
                                      op, imm, rd, t1, d1, t2, d2, expv);
                        if (cnt == 8) begin // loads carry an expected value
                            exp_tag.push_back(rd[tag_w-1:0]);
                            exp_data.push_back(expv);
                        end
                        dispatch(op[op_w-1:0], imm[imm_w-1:0], rd[tag_w-1:0],
                                 t1[tag_w-1:0], d1, t2[tag_w-1:0], d2);
                    end
                    "B": begin
                        cnt = $sscanf(rest, "%h %h", t1, d1);
                        broadcast(t1[tag_w-1:0], d1);
                    end
                    "C": begin
                        cnt = $sscanf(rest, "%h", t1);
                        commit(t1[tag_w-1:0]);
                    end
                    "W": begin
                        cnt = $sscanf(rest, "%h", d1);
                        repeat (d1) next_cycle();
                    end
                    default: begin
                        $display("unknown command in tests file: %s", line);
                        errors++;
                    end
                endcase
                if (cmd == "D" || cmd == "B" || cmd == "C" || cmd == "W") begin
                    rng_state = lcg_step(rng_state);
                    repeat (rng_state[31:30]) next_cycle(); // 0 to 3 idle cycles
                end
            end
            $fclose(fd);
        end

        while (matched < exp_tag.size())
            next_cycle();
        repeat (20) next_cycle(); // room for stray results

        if (stall_cycles == 0) begin
            $display("dispatch was never held off by a busy entry");
            errors++;
        end
        $display("checks %0d, errors %0d", res_checks, errors + res_errors);
        if (errors + res_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- sim/lsu_tests.txt
# D op imm rd rs1_tag rs1_data rs2_tag rs2_data [expected load data]
# B tag data, C tag, W cycles; every field in hex
D a 000 1 0 00000100 0 12345678
W 3
C 1
W 4
D 2 000 2 0 00000100 0 00000000 12345678
D a 004 3 0 00000100 0 80f17f82
W 3
C 3
W 4
D 0 000 4 0 00000104 0 00000000 ffffff82
D 0 007 5 0 00000100 0 00000000 ffffff80
D 4 005 6 0 00000100 0 00000000 0000007f
D 4 006 a 0 00000100 0 00000000 000000f1
D 1 006 7 0 00000100 0 00000000 ffff80f1
D 5 004 8 0 00000100 0 00000000 00007f82
D 1 ffc 9 0 00000108 0 00000000 00007f82
# sb and sh merge into a stored word
D a 008 1 0 00000100 0 aabbccdd
W 3
C 1
W 4
D 8 009 2 0 00000100 0 deadbe11
W 3
C 2
D 9 00a 3 0 00000100 0 cafe2233
W 3
C 3
W 4
D 2 008 b 0 00000100 0 00000000 223311dd
# base from the execute bus, then from another load
D 2 004 c f 00000000 0 00000000 223311dd
W 6
B f 00000104
D a 00c d 0 00000100 0 00000100
W 3
C d
W 4
D 2 000 1 e 00000000 0 00000000 00000100
D 2 004 2 1 00000000 0 00000000 80f17f82
W 2
B e 0000010c
# second dispatch to a busy tag stalls
D 2 000 5 f 00000000 0 00000000 223311dd
D 2 000 5 0 00000100 0 00000000 12345678
W 2
B f 00000108
# non-memory opcodes are dropped
D 3 000 6 0 00000100 0 00000000
D f 010 7 0 00000100 0 00000000
W 8

//--- project.f
design/lsu_pkg.sv
design/ls_decode.sv
design/ls_buffer.sv
design/agen_stage.sv
design/data_mem.sv
design/lsu_top.sv
sim/tb_lsu.sv

//--- run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv --top-module tb_lsu -f project.f -o tb_lsu

./obj_dir/tb_lsu > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
